// ==== common/cpuPkg.sv ====
package cpuPkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] word_t;

	// a7 values understood by the ecall sequencer
	localparam word_t ECALL_WRITE = 64;
	localparam word_t ECALL_EXIT  = 93;

	localparam isaPkg::regIdx_t REG_SP = 5'd2;
	localparam isaPkg::regIdx_t REG_A0 = 5'd10;
	localparam isaPkg::regIdx_t REG_A1 = 5'd11;
	localparam isaPkg::regIdx_t REG_A2 = 5'd12;
	localparam isaPkg::regIdx_t REG_A7 = 5'd17;

	typedef struct packed {
		word_t              address;
		word_t              writeData;
		logic               readEn;
		logic               writeEn;
		isaPkg::loadType_t  loadType;
		isaPkg::storeType_t storeType;
	} memReq_t;

	typedef struct packed {
		word_t fd;
		word_t address;
		word_t len;
	} ecallArgs_t;

	typedef struct packed {
		word_t              aluIn1;
		word_t              aluIn2;
		isaPkg::aluOp_t     aluOp;
		logic               regWriteEn;
		logic               memReadEn;
		logic               memWriteEn;
		isaPkg::loadType_t  loadType;
		isaPkg::storeType_t storeType;
		isaPkg::regIdx_t    rd;
		logic               takeBranch;
		word_t              branchTarget;
		logic               isEcall;
	} exeCtrl_t;

endpackage

// ==== common/isaPkg.sv ====
package isaPkg;

	typedef logic [4:0] regIdx_t;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		SYSTEM = 7'b1110011
	} opcode_t;

	// funct7 values of the R-type ops
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sra, srai
	localparam logic [6:0] F7_SUB  = 7'b0110000;
	localparam logic [6:0] F7_SEQ  = 7'b0000001;
	localparam logic [6:0] F7_SNE  = 7'b0000010;

	typedef struct packed {
		logic [6:0] funct7;
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		regIdx_t    rd;
		opcode_t    opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		regIdx_t     rs1;
		logic [2:0]  funct3;
		regIdx_t     rd;
		opcode_t     opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcode_t    opcode;
	} sType_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_t    opcode;
	} bType_t;

	typedef struct packed {
		logic [19:0] imm;
		regIdx_t     rd;
		opcode_t     opcode;
	} uType_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		regIdx_t    rd;
		opcode_t    opcode;
	} jType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
		sType_t sType;
		bType_t bType;
		uType_t uType;
		jType_t jType;
	} instWord_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_SEQ,
		ALU_SNE, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} aluOp_t;

	typedef enum logic [2:0] {
		LD_NONE, LD_B, LD_H, LD_W, LD_D, LD_BU, LD_HU
	} loadType_t;

	typedef enum logic [2:0] {
		ST_NONE, ST_B, ST_H, ST_W, ST_D
	} storeType_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module rvCore_tb -f rvCore.f -o rvCore_sim

status=0
./obj_dir/rvCore_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without errors"

// ==== rvCore.f ====
common/isaPkg.sv
common/cpuPkg.sv
verilog/intAlu.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/memAlign.sv
verilog/ecallSequencer.sv
verilog/pcCounter.sv
verilog/rvCore.sv
sim/rvCore_checker.sv
sim/rvCore_tb.sv

// ==== sim/rvCore_checker.sv ====
`timescale 1ns/1ps

module rvCore_checker (
	input logic            clk,
	input logic            rst,
	input cpuPkg::word_t   pc,
	input cpuPkg::word_t   cycles,
	input cpuPkg::memReq_t memReq,
	input logic            writeEcall,
	input logic            writeEcallDone,
	input logic            exitEcall
);

	// no bus traffic while an ecall holds the core
	busQuiet: assert property (@(posedge clk) disable iff (rst)
		(writeEcall || exitEcall) |-> !memReq.readEn && !memReq.writeEn)
		else $error("memory request issued during an ecall stall");

	doneBeforeFall: assert property (@(posedge clk) disable iff (rst)
		$fell(writeEcall) |-> $past(writeEcallDone))
		else $error("writeEcall dropped without writeEcallDone");

	heldDuringWrite: assert property (@(posedge clk) disable iff (rst)
		writeEcall |=> $stable(pc) && $stable(cycles))
		else $error("pc or cycles moved during the write ecall");

	exitSticky: assert property (@(posedge clk) disable iff (rst)
		exitEcall |=> exitEcall)
		else $error("exitEcall dropped before reset");

endmodule

// ==== sim/rvCore_tb.sv ====
`timescale 1ns/1ps

module rvCore_tb;
	import isaPkg::*;
	import cpuPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int TEST_CYCLES = 100; // longest program plus ecall wait
	localparam int WATCHDOG_CYCLES = 5 * (TEST_CYCLES + 20);
	localparam logic [31:0] NOP = 32'h0000_0013;
	localparam logic [31:0] ECALL = 32'h0000_0073;

	logic clk;
	logic rst;
	word_t pc;
	instWord_t instr;
	memReq_t memReq;
	word_t memRdata;
	logic writeEcall;
	logic writeEcallDone;
	ecallArgs_t ecallArgs;
	logic exitEcall;
	word_t cycles;

	logic [31:0] prog [256];
	int progLen;
	word_t rdataValue;
	word_t pcTrace[$];
	word_t expTrace[$];
	word_t stAddr[$];
	word_t stData[$];
	storeType_t stType[$];
	word_t expAddr[$];
	word_t expData[$];
	storeType_t expType[$];
	word_t ldAddr[$];
	loadType_t ldType[$];
	word_t expLdAddr[$];
	loadType_t expLdType[$];

	assign instr = prog[pc[9:2]]; // instruction server
	assign memRdata = memReq.readEn ? rdataValue : '0;

	rvCore u_rvCore (
		.clk            (clk),
		.rst            (rst),
		.pc             (pc),
		.instr          (instr),
		.memReq         (memReq),
		.memRdata       (memRdata),
		.writeEcall     (writeEcall),
		.writeEcallDone (writeEcallDone),
		.ecallArgs      (ecallArgs),
		.exitEcall      (exitEcall),
		.cycles         (cycles)
	);

	bind rvCore rvCore_checker u_rvCore_checker (
		.clk            (clk),
		.rst            (rst),
		.pc             (pc),
		.cycles         (cycles),
		.memReq         (memReq),
		.writeEcall     (writeEcall),
		.writeEcallDone (writeEcallDone),
		.exitEcall      (exitEcall)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// executed pcs and bus requests sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && !writeEcall && !exitEcall) begin
			pcTrace.push_back(pc);
			if (memReq.writeEn) begin
				stAddr.push_back(memReq.address);
				stData.push_back(memReq.writeData);
				stType.push_back(memReq.storeType);
			end
			if (memReq.readEn) begin
				ldAddr.push_back(memReq.address);
				ldType.push_back(memReq.loadType);
			end
		end
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkEq(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			abortRun($sformatf("** Error %s: got 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input regIdx_t rs2,
			input regIdx_t rs1, input logic [2:0] f3, input regIdx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input regIdx_t rs1,
			input logic [2:0] f3, input regIdx_t rd, input logic [6:0] opcode);
		return {imm, rs1, f3, rd, opcode};
	endfunction

	function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input regIdx_t rs2,
			input regIdx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bTypeWord(input logic [12:0] imm, input regIdx_t rs2,
			input regIdx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uTypeWord(input logic [19:0] imm, input regIdx_t rd,
			input logic [6:0] opcode);
		return {imm, rd, opcode};
	endfunction

	function automatic logic [31:0] jTypeWord(input logic [20:0] imm, input regIdx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic clearProgram();
		foreach (prog[i]) begin
			prog[i] = NOP;
		end
		progLen = 0;
		expTrace.delete();
		expAddr.delete();
		expData.delete();
		expType.delete();
		expLdAddr.delete();
		expLdType.delete();
	endtask

	task automatic putInstr(input logic [31:0] word);
		prog[progLen] = word;
		expTrace.push_back(word_t'(progLen * 4));
		progLen++;
	endtask

	task automatic skipSlot(input logic [31:0] word);
		prog[progLen] = word; // jumped over and never executed
		progLen++;
	endtask

	task automatic expectStore(input word_t addr, input word_t data, input storeType_t kind);
		expAddr.push_back(addr);
		expData.push_back(data);
		expType.push_back(kind);
	endtask

	task automatic exitSequence();
		putInstr(iTypeWord(12'd93, 5'd0, 3'b000, REG_A7, OP_IMM));
		putInstr(ECALL);
	endtask

	// lui + addi of a random 32-bit value
	task automatic loadUpper(input regIdx_t rd, output word_t value);
		logic [19:0] hi;
		logic [11:0] lo;
		hi = 20'($urandom);
		lo = 12'($urandom);
		putInstr(uTypeWord(hi, rd, LUI));
		putInstr(iTypeWord(lo, rd, 3'b000, rd, OP_IMM));
		value = {{32{hi[19]}}, hi, 12'h000} + {{52{lo[11]}}, lo};
	endtask

	task automatic startProgram();
		@(posedge clk);
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		pcTrace.delete();
		stAddr.delete();
		stData.delete();
		stType.delete();
		ldAddr.delete();
		ldType.delete();
		rst <= 1'b0;
	endtask

	task automatic finishProgram();
		word_t heldPc;
		word_t heldCycles;
		int n;
		n = 0;
		while (!exitEcall && n < TEST_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!exitEcall) begin
			abortRun("program did not reach the exit ecall in time");
		end
		checkEq("pc", pc, word_t'((progLen - 1) * 4));
		checkEq("cycles", cycles, word_t'(expTrace.size() - 1)); // exit ecall not counted
		heldPc = pc;
		heldCycles = cycles;
		repeat (3) begin
			@(negedge clk);
			checkEq("exitEcall", word_t'(exitEcall), 1);
			checkEq("pc", pc, heldPc);
			checkEq("cycles", cycles, heldCycles);
		end
		checkEq("pc trace length", word_t'(pcTrace.size()), word_t'(expTrace.size()));
		foreach (expTrace[i]) begin
			checkEq($sformatf("pc[%0d]", i), pcTrace[i], expTrace[i]);
		end
		checkEq("store count", word_t'(stAddr.size()), word_t'(expAddr.size()));
		foreach (expAddr[i]) begin
			checkEq($sformatf("memReq.address[%0d]", i), stAddr[i], expAddr[i]);
			checkEq($sformatf("memReq.writeData[%0d]", i), stData[i], expData[i]);
			checkEq($sformatf("memReq.storeType[%0d]", i), word_t'(stType[i]),
				word_t'(expType[i]));
		end
		checkEq("load count", word_t'(ldAddr.size()), word_t'(expLdAddr.size()));
		foreach (expLdAddr[i]) begin
			checkEq($sformatf("memReq.address[load %0d]", i), ldAddr[i], expLdAddr[i]);
			checkEq($sformatf("memReq.loadType[%0d]", i), word_t'(ldType[i]),
				word_t'(expLdType[i]));
		end
	endtask

	// result of x5 op x6 (or imm) lands in x7 and goes out by sd
	task automatic aluCase(input logic [31:0] word, input word_t expected);
		word_t addr;
		addr = word_t'(8 * expAddr.size());
		putInstr(word);
		putInstr(sTypeWord(12'(addr), 5'd7, 5'd0, 3'b011));
		expectStore(addr, expected, ST_D);
	endtask

	task automatic aluOperations();
		word_t a;
		word_t b;
		word_t c;
		logic [11:0] imm;
		logic [5:0] sh;
		clearProgram();
		aluCase(iTypeWord(12'd0, REG_SP, 3'b000, 5'd7, OP_IMM), word_t'(4096)); // sp at reset
		loadUpper(5'd5, a);
		loadUpper(5'd6, b);
		imm = 12'($urandom);
		sh = 6'($urandom);
		c = {{52{imm[11]}}, imm};
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b000, 5'd7), a + b);
		aluCase(rTypeWord(F7_SUB, 5'd6, 5'd5, 3'b000, 5'd7), a - b);
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b001, 5'd7), a << b[5:0]);
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b010, 5'd7), word_t'($signed(a) < $signed(b)));
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b011, 5'd7), word_t'(a < b));
		aluCase(rTypeWord(F7_SEQ, 5'd6, 5'd5, 3'b010, 5'd7), word_t'(a == b));
		aluCase(rTypeWord(F7_SNE, 5'd6, 5'd5, 3'b010, 5'd7), word_t'(a != b));
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b100, 5'd7), a ^ b);
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b101, 5'd7), a >> b[5:0]);
		aluCase(rTypeWord(F7_ALT, 5'd6, 5'd5, 3'b101, 5'd7), word_t'($signed(a) >>> b[5:0]));
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b110, 5'd7), a | b);
		aluCase(rTypeWord(F7_BASE, 5'd6, 5'd5, 3'b111, 5'd7), a & b);
		aluCase(iTypeWord(imm, 5'd5, 3'b000, 5'd7, OP_IMM), a + c);
		aluCase(iTypeWord(imm, 5'd5, 3'b010, 5'd7, OP_IMM), word_t'($signed(a) < $signed(c)));
		aluCase(iTypeWord(imm, 5'd5, 3'b011, 5'd7, OP_IMM), word_t'(a < c));
		aluCase(iTypeWord(imm, 5'd5, 3'b100, 5'd7, OP_IMM), a ^ c);
		aluCase(iTypeWord(imm, 5'd5, 3'b110, 5'd7, OP_IMM), a | c);
		aluCase(iTypeWord(imm, 5'd5, 3'b111, 5'd7, OP_IMM), a & c);
		aluCase(iTypeWord({6'b000000, sh}, 5'd5, 3'b001, 5'd7, OP_IMM), a << sh);
		aluCase(iTypeWord({6'b000000, sh}, 5'd5, 3'b101, 5'd7, OP_IMM), a >> sh);
		aluCase(iTypeWord({6'b010000, sh}, 5'd5, 3'b101, 5'd7, OP_IMM),
			word_t'($signed(a) >>> sh));
		exitSequence();
		startProgram();
		finishProgram();
	endtask

	task automatic loadCase(input logic [2:0] f3, input loadType_t kind, input word_t expected);
		word_t addr;
		logic [11:0] imm;
		addr = word_t'(8 * expAddr.size());
		imm = 12'($urandom);
		putInstr(iTypeWord(imm, 5'd0, f3, 5'd7, LOAD));
		putInstr(sTypeWord(12'(addr), 5'd7, 5'd0, 3'b011));
		expectStore(addr, expected, ST_D);
		expLdAddr.push_back({{52{imm[11]}}, imm});
		expLdType.push_back(kind);
	endtask

	task automatic loadExtension();
		word_t rv;
		rv = {$urandom, $urandom};
		@(posedge clk);
		rdataValue <= rv;
		clearProgram();
		loadCase(3'b000, LD_B, {{56{rv[7]}}, rv[7:0]});
		loadCase(3'b001, LD_H, {{48{rv[15]}}, rv[15:0]});
		loadCase(3'b010, LD_W, {{32{rv[31]}}, rv[31:0]});
		loadCase(3'b011, LD_D, rv);
		loadCase(3'b100, LD_BU, {56'd0, rv[7:0]});
		loadCase(3'b101, LD_HU, {48'd0, rv[15:0]});
		exitSequence();
		startProgram();
		finishProgram();
	endtask

	task automatic storeCase(input logic [2:0] f3, input storeType_t kind, input word_t data,
			input word_t base);
		logic [11:0] imm;
		imm = 12'($urandom);
		putInstr(sTypeWord(imm, 5'd5, 5'd8, f3));
		expectStore(base + {{52{imm[11]}}, imm}, data, kind);
	endtask

	task automatic storeReplication();
		word_t base;
		word_t v;
		clearProgram();
		base = word_t'($urandom_range(0, 2047));
		putInstr(iTypeWord(12'(base), 5'd0, 3'b000, 5'd8, OP_IMM));
		loadUpper(5'd5, v);
		storeCase(3'b000, ST_B, {8{v[7:0]}}, base);
		storeCase(3'b001, ST_H, {4{v[15:0]}}, base);
		storeCase(3'b010, ST_W, {2{v[31:0]}}, base);
		storeCase(3'b011, ST_D, v, base);
		exitSequence();
		startProgram();
		finishProgram();
	endtask

	// forward branch over one slot
	task automatic branchCase(input logic [2:0] f3, input regIdx_t rs1, input regIdx_t rs2,
			input logic taken);
		putInstr(bTypeWord(13'd8, rs2, rs1, f3));
		if (taken) begin
			skipSlot(NOP);
		end else begin
			putInstr(NOP);
		end
	endtask

	task automatic branchAndJump();
		word_t link;
		word_t target;
		logic [19:0] hi;
		clearProgram();
		putInstr(iTypeWord(12'd5, 5'd0, 3'b000, 5'd5, OP_IMM));
		putInstr(iTypeWord(12'hffd, 5'd0, 3'b000, 5'd6, OP_IMM)); // -3
		branchCase(3'b000, 5'd5, 5'd6, 1'b0);
		branchCase(3'b000, 5'd5, 5'd5, 1'b1);
		branchCase(3'b001, 5'd5, 5'd5, 1'b0);
		branchCase(3'b001, 5'd5, 5'd6, 1'b1);
		branchCase(3'b100, 5'd5, 5'd6, 1'b0);
		branchCase(3'b100, 5'd6, 5'd5, 1'b1);
		branchCase(3'b101, 5'd6, 5'd5, 1'b0);
		branchCase(3'b101, 5'd5, 5'd6, 1'b1);
		branchCase(3'b110, 5'd6, 5'd5, 1'b0); // -3 is huge unsigned
		branchCase(3'b110, 5'd5, 5'd6, 1'b1);
		branchCase(3'b111, 5'd5, 5'd6, 1'b0);
		branchCase(3'b111, 5'd6, 5'd5, 1'b1);
		link = word_t'(progLen * 4 + 4);
		putInstr(jTypeWord(21'd8, 5'd1));
		skipSlot(NOP);
		putInstr(sTypeWord(12'd0, 5'd1, 5'd0, 3'b011));
		expectStore(0, link, ST_D);
		target = word_t'((progLen + 3) * 4);
		link = word_t'((progLen + 1) * 4 + 4);
		putInstr(iTypeWord(12'(target), 5'd0, 3'b000, 5'd7, OP_IMM));
		putInstr(iTypeWord(12'd1, 5'd7, 3'b000, 5'd3, JALR)); // odd target with bit 0 dropped
		skipSlot(NOP);
		putInstr(sTypeWord(12'd8, 5'd3, 5'd0, 3'b011));
		expectStore(8, link, ST_D);
		hi = 20'($urandom);
		putInstr(uTypeWord(hi, 5'd9, LUI));
		putInstr(sTypeWord(12'd16, 5'd9, 5'd0, 3'b011));
		expectStore(16, {{32{hi[19]}}, hi, 12'h000}, ST_D);
		hi = 20'($urandom);
		target = word_t'(progLen * 4);
		putInstr(uTypeWord(hi, 5'd11, AUIPC));
		putInstr(sTypeWord(12'd24, 5'd11, 5'd0, 3'b011));
		expectStore(24, target + {{32{hi[19]}}, hi, 12'h000}, ST_D);
		exitSequence();
		startProgram();
		finishProgram();
	endtask

	task automatic ecallHandshake();
		word_t fd;
		word_t addr;
		word_t len;
		word_t ecallPc;
		int delay;
		int n;
		clearProgram();
		fd = word_t'($urandom_range(1, 7));
		addr = word_t'($urandom_range(0, 2047));
		len = word_t'($urandom_range(1, 255));
		putInstr(iTypeWord(12'(fd), 5'd0, 3'b000, REG_A0, OP_IMM));
		putInstr(iTypeWord(12'(addr), 5'd0, 3'b000, REG_A1, OP_IMM));
		putInstr(iTypeWord(12'(len), 5'd0, 3'b000, REG_A2, OP_IMM));
		putInstr(iTypeWord(12'd64, 5'd0, 3'b000, REG_A7, OP_IMM));
		putInstr(iTypeWord(12'h055, 5'd0, 3'b000, 5'd5, OP_IMM));
		ecallPc = word_t'(progLen * 4);
		putInstr(ECALL);
		putInstr(sTypeWord(12'd0, 5'd5, 5'd0, 3'b011)); // store waits behind the ecall
		expectStore(0, 64'h55, ST_D);
		exitSequence();
		delay = $urandom_range(1, 6);
		startProgram();
		n = 0;
		while (!writeEcall && n < TEST_CYCLES) begin
			@(negedge clk);
			n++;
		end
		if (!writeEcall) begin
			abortRun("write ecall was never raised");
		end
		checkEq("ecallArgs.fd", ecallArgs.fd, fd);
		checkEq("ecallArgs.address", ecallArgs.address, addr);
		checkEq("ecallArgs.len", ecallArgs.len, len);
		checkEq("pc", pc, ecallPc + 4);
		checkEq("cycles", cycles, ecallPc / 4 + 1);
		repeat (delay) begin
			@(negedge clk);
			checkEq("writeEcall", word_t'(writeEcall), 1);
			checkEq("pc", pc, ecallPc + 4);
			checkEq("cycles", cycles, ecallPc / 4 + 1);
			checkEq("memReq.writeEn", word_t'(memReq.writeEn), 0);
			checkEq("memReq.readEn", word_t'(memReq.readEn), 0);
		end
		@(posedge clk);
		writeEcallDone <= 1'b1;
		@(posedge clk);
		writeEcallDone <= 1'b0;
		@(negedge clk);
		checkEq("writeEcall", word_t'(writeEcall), 0);
		finishProgram();
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("watchdog expired before the tests finished");
	end

	initial begin
		rst <= 1'b1;
		writeEcallDone <= 1'b0;
		rdataValue <= '0;
		void'($urandom(61835));
		aluOperations();
		loadExtension();
		storeReplication();
		branchAndJump();
		ecallHandshake();
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== verilog/ecallSequencer.sv ====
`timescale 1ns/1ps

module ecallSequencer (
	input  logic          clk,
	input  logic          rst,
	input  logic          isEcall,
	input  cpuPkg::word_t a7Data,
	input  logic          writeEcallDone,
	output logic          stall,
	output logic          writeEcall,
	output logic          exitEcall
);
	import cpuPkg::*;

	typedef enum logic [1:0] {RUN, WRITE_WAIT, HALTED} state_t;

	state_t state;
	state_t nextState;
	logic isWrite;
	logic isExit;

	assign isWrite = isEcall && a7Data == ECALL_WRITE;
	assign isExit = isEcall && a7Data == ECALL_EXIT;

	always_comb begin
		nextState = state;
		case (state)
			RUN: begin
				if (isWrite) begin
					nextState = WRITE_WAIT;
				end else if (isExit) begin
					nextState = HALTED;
				end
			end
			WRITE_WAIT: nextState = writeEcallDone ? RUN : WRITE_WAIT;
			HALTED:     nextState = HALTED; // left only by reset
			default:    nextState = RUN;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= RUN;
		end else begin
			state <= nextState;
		end
	end

	// exit holds pc on the ecall itself
	assign stall = state != RUN || isExit;
	assign writeEcall = state == WRITE_WAIT;
	assign exitEcall = state == HALTED;

endmodule

// ==== verilog/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder (
	input  isaPkg::instWord_t instr,
	input  cpuPkg::word_t     pc,
	input  cpuPkg::word_t     rs1Data,
	input  cpuPkg::word_t     rs2Data,
	output cpuPkg::exeCtrl_t  ctrl,
	output isaPkg::regIdx_t   rs1,
	output isaPkg::regIdx_t   rs2
);
	import isaPkg::*;
	import cpuPkg::*;

	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;
	aluOp_t regOp;
	aluOp_t immOp;
	logic regOpValid;
	logic immOpValid;
	logic branchCond;
	loadType_t loadType;
	storeType_t storeType;

	assign rs1 = instr.rType.rs1;
	assign rs2 = instr.rType.rs2;

	assign immI = {{(XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
	assign immS = {{(XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
	assign immB = {{(XLEN-12){instr.bType.imm12}}, instr.bType.imm11, instr.bType.imm10_5,
		instr.bType.imm4_1, 1'b0};
	assign immU = {{(XLEN-32){instr.uType.imm[19]}}, instr.uType.imm, 12'd0};
	assign immJ = {{(XLEN-20){instr.jType.imm20}}, instr.jType.imm19_12, instr.jType.imm11,
		instr.jType.imm10_1, 1'b0};

	always_comb begin
		regOp = ALU_ADD;
		regOpValid = 1'b1;
		case ({instr.rType.funct7, instr.rType.funct3})
			{F7_BASE, 3'b000}: regOp = ALU_ADD;
			{F7_SUB,  3'b000}: regOp = ALU_SUB;
			{F7_BASE, 3'b001}: regOp = ALU_SLL;
			{F7_BASE, 3'b010}: regOp = ALU_SLT;
			{F7_SEQ,  3'b010}: regOp = ALU_SEQ;
			{F7_SNE,  3'b010}: regOp = ALU_SNE;
			{F7_BASE, 3'b011}: regOp = ALU_SLTU;
			{F7_BASE, 3'b100}: regOp = ALU_XOR;
			{F7_BASE, 3'b101}: regOp = ALU_SRL;
			{F7_ALT,  3'b101}: regOp = ALU_SRA;
			{F7_BASE, 3'b110}: regOp = ALU_OR;
			{F7_BASE, 3'b111}: regOp = ALU_AND;
			default: regOpValid = 1'b0;
		endcase
	end

	// shift immediates carry a 6-bit shamt, so only funct7[6:1] selects
	always_comb begin
		immOp = ALU_ADD;
		immOpValid = 1'b1;
		case (instr.iType.funct3)
			3'b000: immOp = ALU_ADD;
			3'b010: immOp = ALU_SLT;
			3'b011: immOp = ALU_SLTU;
			3'b100: immOp = ALU_XOR;
			3'b110: immOp = ALU_OR;
			3'b111: immOp = ALU_AND;
			3'b001: begin
				immOp = ALU_SLL;
				immOpValid = instr.rType.funct7[6:1] == F7_BASE[6:1];
			end
			default: begin
				immOp = (instr.rType.funct7[6:1] == F7_ALT[6:1]) ? ALU_SRA : ALU_SRL;
				immOpValid = instr.rType.funct7[6:1] == F7_ALT[6:1] ||
					instr.rType.funct7[6:1] == F7_BASE[6:1];
			end
		endcase
	end

	always_comb begin
		case (instr.iType.funct3)
			3'b000: loadType = LD_B;
			3'b001: loadType = LD_H;
			3'b010: loadType = LD_W;
			3'b011: loadType = LD_D;
			3'b100: loadType = LD_BU;
			3'b101: loadType = LD_HU;
			default: loadType = LD_NONE;
		endcase
		case (instr.sType.funct3)
			3'b000: storeType = ST_B;
			3'b001: storeType = ST_H;
			3'b010: storeType = ST_W;
			3'b011: storeType = ST_D;
			default: storeType = ST_NONE;
		endcase
	end

	always_comb begin
		case (instr.bType.funct3)
			3'b000: branchCond = rs1Data == rs2Data;
			3'b001: branchCond = rs1Data != rs2Data;
			3'b100: branchCond = $signed(rs1Data) < $signed(rs2Data);
			3'b101: branchCond = $signed(rs1Data) >= $signed(rs2Data);
			3'b110: branchCond = rs1Data < rs2Data;
			3'b111: branchCond = rs1Data >= rs2Data;
			default: branchCond = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = ALU_ADD;
		ctrl.rd = instr.rType.rd;
		ctrl.aluIn1 = rs1Data;
		case (instr.rType.opcode)
			OP: begin
				ctrl.regWriteEn = regOpValid;
				ctrl.aluIn2 = rs2Data;
				ctrl.aluOp = regOp;
			end
			OP_IMM: begin
				ctrl.regWriteEn = immOpValid;
				ctrl.aluIn2 = immI;
				ctrl.aluOp = immOp;
			end
			LOAD: begin
				ctrl.regWriteEn = loadType != LD_NONE;
				ctrl.memReadEn = loadType != LD_NONE;
				ctrl.loadType = loadType;
				ctrl.aluIn2 = immI;
			end
			STORE: begin
				ctrl.memWriteEn = storeType != ST_NONE;
				ctrl.storeType = storeType;
				ctrl.aluIn2 = immS;
			end
			BRANCH: begin
				ctrl.takeBranch = branchCond;
				ctrl.branchTarget = pc + immB;
			end
			JAL: begin
				ctrl.regWriteEn = 1'b1;
				ctrl.aluIn1 = pc; // link = pc + 4
				ctrl.aluIn2 = word_t'(4);
				ctrl.takeBranch = 1'b1;
				ctrl.branchTarget = pc + immJ;
			end
			JALR: begin
				ctrl.regWriteEn = instr.iType.funct3 == 3'b000;
				ctrl.aluIn1 = pc;
				ctrl.aluIn2 = word_t'(4);
				ctrl.takeBranch = instr.iType.funct3 == 3'b000;
				ctrl.branchTarget = (rs1Data + immI) & ~word_t'(1);
			end
			LUI: begin
				ctrl.regWriteEn = 1'b1;
				ctrl.aluIn1 = '0;
				ctrl.aluIn2 = immU;
			end
			AUIPC: begin
				ctrl.regWriteEn = 1'b1;
				ctrl.aluIn1 = pc;
				ctrl.aluIn2 = immU;
			end
			SYSTEM: ctrl.isEcall = instr.iType.funct3 == 3'b000 && instr.iType.imm == 12'd0;
			default: ; // unknown opcode acts as a no-op
		endcase
	end

endmodule

// ==== verilog/intAlu.sv ====
`timescale 1ns/1ps

module intAlu (
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	input  isaPkg::aluOp_t op,
	output cpuPkg::word_t  result
);
	import isaPkg::*;
	import cpuPkg::*;

	logic [5:0] shamt;

	assign shamt = b[5:0]; // RV64 shift range

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = word_t'($signed(a) < $signed(b));
			ALU_SLTU: result = word_t'(a < b);
			ALU_SEQ:  result = word_t'(a == b);
			ALU_SNE:  result = word_t'(a != b);
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

endmodule

// ==== verilog/memAlign.sv ====
`timescale 1ns/1ps

module memAlign (
	input  cpuPkg::exeCtrl_t ctrl,
	input  cpuPkg::word_t    aluResult,
	input  cpuPkg::word_t    rs2Data,
	input  cpuPkg::word_t    memRdata,
	input  logic             stall,
	output cpuPkg::memReq_t  memReq,
	output cpuPkg::word_t    writeBack
);
	import isaPkg::*;
	import cpuPkg::*;

	word_t loadData;

	always_comb begin
		memReq.address = aluResult;
		memReq.readEn = ctrl.memReadEn && !stall;
		memReq.writeEn = ctrl.memWriteEn && !stall;
		memReq.loadType = ctrl.loadType;
		memReq.storeType = ctrl.storeType;
		case (ctrl.storeType) // replicate across the bus
			ST_B:    memReq.writeData = {8{rs2Data[7:0]}};
			ST_H:    memReq.writeData = {4{rs2Data[15:0]}};
			ST_W:    memReq.writeData = {2{rs2Data[31:0]}};
			ST_D:    memReq.writeData = rs2Data;
			default: memReq.writeData = '0;
		endcase
	end

	always_comb begin
		case (ctrl.loadType)
			LD_B:    loadData = {{(XLEN-8){memRdata[7]}}, memRdata[7:0]};
			LD_H:    loadData = {{(XLEN-16){memRdata[15]}}, memRdata[15:0]};
			LD_W:    loadData = {{(XLEN-32){memRdata[31]}}, memRdata[31:0]};
			LD_D:    loadData = memRdata;
			LD_BU:   loadData = {{(XLEN-8){1'b0}}, memRdata[7:0]};
			LD_HU:   loadData = {{(XLEN-16){1'b0}}, memRdata[15:0]};
			default: loadData = '0;
		endcase
	end

	assign writeBack = ctrl.memReadEn ? loadData : aluResult;

endmodule

// ==== verilog/pcCounter.sv ====
`timescale 1ns/1ps

module pcCounter #(
	parameter cpuPkg::word_t resetAddr = '0
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          stall,
	input  logic          takeBranch,
	input  cpuPkg::word_t branchTarget,
	output cpuPkg::word_t pc,
	output cpuPkg::word_t cycles
);
	import cpuPkg::*;

	word_t nextPc;

	assign nextPc = takeBranch ? branchTarget : pc + word_t'(4);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= resetAddr;
			cycles <= '0;
		end else if (!stall) begin
			pc <= nextPc;
			cycles <= cycles + word_t'(1); // only cycles that did work
		end
	end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
	parameter cpuPkg::word_t stackTop = 4096
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,
	input  logic               writeEn,
	input  isaPkg::regIdx_t    rd,
	input  cpuPkg::word_t      writeData,
	input  isaPkg::regIdx_t    rs1,
	input  isaPkg::regIdx_t    rs2,
	output cpuPkg::word_t      rs1Data,
	output cpuPkg::word_t      rs2Data,
	output cpuPkg::word_t      a7Data,
	output cpuPkg::ecallArgs_t ecallArgs
);
	import cpuPkg::*;

	word_t regs [32];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= (i == REG_SP) ? stackTop : '0;
			end
		end else if (writeEn && !stall && rd != '0) begin
			regs[rd] <= writeData;
		end
	end

	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

	// ecall number and write arguments
	assign a7Data = regs[REG_A7];
	assign ecallArgs.fd = regs[REG_A0];
	assign ecallArgs.address = regs[REG_A1];
	assign ecallArgs.len = regs[REG_A2];

endmodule

// ==== verilog/rvCore.sv ====
`timescale 1ns/1ps

module rvCore #(
	parameter cpuPkg::word_t resetAddr = '0,
	parameter cpuPkg::word_t stackTop = 4096
) (
	input  logic               clk,
	input  logic               rst,
	output cpuPkg::word_t      pc,
	input  isaPkg::instWord_t  instr,
	output cpuPkg::memReq_t    memReq,
	input  cpuPkg::word_t      memRdata,
	output logic               writeEcall,
	input  logic               writeEcallDone,
	output cpuPkg::ecallArgs_t ecallArgs,
	output logic               exitEcall,
	output cpuPkg::word_t      cycles
);
	import isaPkg::*;
	import cpuPkg::*;

	exeCtrl_t ctrl;
	regIdx_t rs1;
	regIdx_t rs2;
	word_t rs1Data;
	word_t rs2Data;
	word_t a7Data;
	word_t aluResult;
	word_t writeBack;
	logic stall;

	instDecoder u_instDecoder (
		.instr   (instr),
		.pc      (pc),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data),
		.ctrl    (ctrl),
		.rs1     (rs1),
		.rs2     (rs2)
	);

	regFile #(
		.stackTop (stackTop)
	) u_regFile (
		.clk       (clk),
		.rst       (rst),
		.stall     (stall),
		.writeEn   (ctrl.regWriteEn),
		.rd        (ctrl.rd),
		.writeData (writeBack),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.a7Data    (a7Data),
		.ecallArgs (ecallArgs)
	);

	intAlu u_intAlu (
		.a      (ctrl.aluIn1),
		.b      (ctrl.aluIn2),
		.op     (ctrl.aluOp),
		.result (aluResult)
	);

	memAlign u_memAlign (
		.ctrl      (ctrl),
		.aluResult (aluResult),
		.rs2Data   (rs2Data),
		.memRdata  (memRdata),
		.stall     (stall),
		.memReq    (memReq),
		.writeBack (writeBack)
	);

	ecallSequencer u_ecallSequencer (
		.clk            (clk),
		.rst            (rst),
		.isEcall        (ctrl.isEcall),
		.a7Data         (a7Data),
		.writeEcallDone (writeEcallDone),
		.stall          (stall),
		.writeEcall     (writeEcall),
		.exitEcall      (exitEcall)
	);

	pcCounter #(
		.resetAddr (resetAddr)
	) u_pcCounter (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.takeBranch   (ctrl.takeBranch),
		.branchTarget (ctrl.branchTarget),
		.pc           (pc),
		.cycles       (cycles)
	);

endmodule
